// File: shuffle_pkg.sv
// Shared sizes, element-width codes and the stage-enable rule of the read shuffler
// Imported by the RTL modules and by the testbench model
package shuffle_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Lanes in one cluster
  localparam int unsigned NR_LANES     = 4;
  // Clusters served by the wide bus
  localparam int unsigned NR_CLUSTERS  = 4;
  // Data width seen by one cluster
  localparam int unsigned CLUSTER_DW   = 128;
  // Full memory bus width
  localparam int unsigned TOTAL_DW     = NR_CLUSTERS * CLUSTER_DW;
  // One stage per doubling of the block size, from NR_LANES bits up
  localparam int unsigned NUM_STAGES   = $clog2(CLUSTER_DW / NR_LANES);
  // Load requests that may be outstanding at once
  localparam int unsigned NUM_TRACKERS = 8;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [$clog2(NUM_TRACKERS)-1:0] ptr_t;
  // One extra bit so a full queue can be told from an empty one
  typedef logic [$clog2(NUM_TRACKERS):0]   cnt_t;

  // Element width of a load
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } vew_e;

  // Wide read beat, cluster c owns bits c*CLUSTER_DW upward
  typedef logic [TOTAL_DW-1:0] beat_t;

  ////////////////////////////////////////////////////////////
  // Stage enable
  ////////////////////////////////////////////////////////////

  // Stage s permutes blocks of NR_LANES << s bits
  // Narrow elements need the larger blocks regrouped, wide ones need none
  function automatic logic stage_en(int s, vew_e vew);
    return s >= 3 + int'(vew);
  endfunction

endpackage

// File: shuffle_perm.sv
// Block permutation of one shuffle stage, purely combinational
// Instantiated once per pipeline slice with the stage index as STAGE
`timescale 1ns/1ps

module shuffle_perm #(
  parameter int unsigned STAGE = 0
) (
  input  logic               en_i,
  input  shuffle_pkg::beat_t data_i,
  output shuffle_pkg::beat_t data_o
);

  import shuffle_pkg::*;

  // Block width in bits grows with the stage index
  localparam int unsigned BLK_W    = NR_LANES << STAGE;
  // Two blocks per cluster form one interleave group
  localparam int unsigned GRP_BLKS = 2 * NR_CLUSTERS;
  // Groups across the whole beat
  localparam int unsigned NUM_GRP  = TOTAL_DW / (BLK_W * GRP_BLKS);

  beat_t shuffled;

  ////////////////////////////////////////////////////////////
  // Interleave
  ////////////////////////////////////////////////////////////

  // Output block 2i+j of a group takes input block j*NR_CLUSTERS+i
  // Pairs of blocks that belong to one cluster end up adjacent
  always_comb begin
    shuffled = '0;
    for (int g = 0; g < NUM_GRP; g++) begin
      for (int i = 0; i < NR_CLUSTERS; i++) begin
        for (int j = 0; j < 2; j++) begin
          shuffled[(g * GRP_BLKS + 2 * i + j) * BLK_W +: BLK_W] =
            data_i[(g * GRP_BLKS + j * NR_CLUSTERS + i) * BLK_W +: BLK_W];
        end
      end
    end
  end

  // Bypass when the element width does not need this stage
  assign data_o = en_i ? shuffled : data_i;

endmodule

// File: shuffle_slice.sv
// One pipeline slice of the read shuffler
// Optional one-entry holding register followed by the block permutation of its stage
`timescale 1ns/1ps

module shuffle_slice #(
  parameter int unsigned STAGE   = 0,
  parameter bit          HAS_REG = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Upstream link
  input  logic               valid_i,
  output logic               ready_o,
  input  shuffle_pkg::beat_t data_i,
  input  logic               last_i,
  // Permutation enable for the beat held by this slice
  input  logic               en_i,
  // Downstream link
  output logic               valid_o,
  input  logic               ready_i,
  output shuffle_pkg::beat_t data_o,
  output logic               last_o,
  // Last beat of a request leaves the slice
  output logic               last_hs_o
);

  import shuffle_pkg::*;

  // Beat currently presented by this slice, before permutation
  beat_t held_data;

  if (HAS_REG) begin : gen_reg

    logic  valid_q;
    logic  last_q;
    beat_t data_q;

    // Full throughput, a new beat may enter while the old one leaves
    assign ready_o = ~valid_q | ready_i;

    // Handshake state and the last flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
        last_q  <= 1'b0;
      end else if (ready_o) begin
        valid_q <= valid_i;
        if (valid_i) begin
          last_q <= last_i;
        end
      end
    end

    // Payload only moves on an accepted beat
    always_ff @(posedge clk_i) begin
      if (valid_i && ready_o) begin
        data_q <= data_i;
      end
    end

    assign valid_o   = valid_q;
    assign last_o    = last_q;
    assign held_data = data_q;

  end else begin : gen_pass

    // Combinational slice, link passes straight through
    assign ready_o   = ready_i;
    assign valid_o   = valid_i;
    assign last_o    = last_i;
    assign held_data = data_i;

  end

  // Permute under the width of the request owning the held beat
  shuffle_perm #(
    .STAGE (STAGE)
  ) i_perm (
    .en_i   (en_i),
    .data_i (held_data),
    .data_o (data_o)
  );

  // Advances this stage's issue pointer in the tracker
  assign last_hs_o = valid_o & ready_i & last_o;

endmodule

// File: shuffle_tracker.sv
// Queue of accepted load requests with one issue pointer per shuffle stage
// Gives every stage the enable that matches the request whose beat it holds
`timescale 1ns/1ps

module shuffle_tracker (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Request channel
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  shuffle_pkg::vew_e                   req_vew_i,
  // Last-beat handshake out of each slice
  input  logic [shuffle_pkg::NUM_STAGES-1:0]  last_hs_i,
  // Permutation enable per stage
  output logic [shuffle_pkg::NUM_STAGES-1:0]  en_o,
  // Some accepted request still has beats to enter stage 0
  output logic                                pending_o
);

  import shuffle_pkg::*;

  // Element width per entry
  vew_e vew_q [NUM_TRACKERS];

  ptr_t acc_ptr_q;
  ptr_t iss_ptr_q [NUM_STAGES];
  // Entries held until the last beat leaves the fork
  cnt_t cnt_q;
  // Entries stage 0 has not yet finished
  cnt_t pend_q;

  logic req_hs;
  logic retire;

  ////////////////////////////////////////////////////////////
  // Accept side
  ////////////////////////////////////////////////////////////

  // Full queue blocks new requests
  assign req_ready_o = (cnt_q != cnt_t'(NUM_TRACKERS));
  assign req_hs      = req_valid_i & req_ready_o;

  // Last stage closing a request frees its entry
  assign retire = last_hs_i[NUM_STAGES-1];

  // Width store, written in the cycle of acceptance
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      vew_q[acc_ptr_q] <= req_vew_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_ptr_q <= '0;
      cnt_q     <= '0;
      pend_q    <= '0;
      for (int s = 0; s < NUM_STAGES; s++) begin
        iss_ptr_q[s] <= '0;
      end
    end else begin
      // Power-of-two depth, pointers wrap on their own
      if (req_hs) begin
        acc_ptr_q <= acc_ptr_q + ptr_t'(1);
      end
      cnt_q  <= cnt_q + cnt_t'(req_hs) - cnt_t'(retire);
      pend_q <= pend_q + cnt_t'(req_hs) - cnt_t'(last_hs_i[0]);
      // Each stage moves on once its last beat of a request has left
      for (int s = 0; s < NUM_STAGES; s++) begin
        if (last_hs_i[s]) begin
          iss_ptr_q[s] <= iss_ptr_q[s] + ptr_t'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < NUM_STAGES; s++) begin
      en_o[s] = stage_en(s, vew_q[iss_ptr_q[s]]);
    end
  end

  // Stage 0 pointer is behind the accept pointer
  assign pending_o = (pend_q != '0);

endmodule

// File: cluster_fork.sv
// Delivers each shuffled beat to every cluster, with one ready per cluster
// Completes the incoming link once all clusters have taken the beat
`timescale 1ns/1ps

module cluster_fork (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  // Link from the last slice
  input  logic                                                        valid_i,
  output logic                                                        ready_o,
  input  shuffle_pkg::beat_t                                          data_i,
  input  logic                                                        last_i,
  // Cluster side
  output logic [shuffle_pkg::NR_CLUSTERS-1:0]                         cl_valid_o,
  input  logic [shuffle_pkg::NR_CLUSTERS-1:0]                         cl_ready_i,
  output logic [shuffle_pkg::NR_CLUSTERS-1:0][shuffle_pkg::CLUSTER_DW-1:0] cl_data_o,
  output logic                                                        cl_last_o
);

  import shuffle_pkg::*;

  // Clusters that took the current beat in an earlier cycle
  logic [NR_CLUSTERS-1:0] done_q;
  // Taken now or before
  logic [NR_CLUSTERS-1:0] taken;

  // Offer only to clusters still waiting
  assign cl_valid_o = {NR_CLUSTERS{valid_i}} & ~done_q;
  assign taken      = done_q | (cl_valid_o & cl_ready_i);

  // Last cluster's handshake ends the beat
  assign ready_o = &taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= '0;
    end else if (valid_i) begin
      // Clear for the next beat, else remember partial delivery
      done_q <= ready_o ? '0 : taken;
    end
  end

  // Each cluster gets its own slice of the beat
  for (genvar c = 0; c < NR_CLUSTERS; c++) begin : gen_slice
    assign cl_data_o[c] = data_i[c * CLUSTER_DW +: CLUSTER_DW];
  end

  assign cl_last_o = last_i;

endmodule

// File: shuffle_stage.sv
// Read-side memory response shuffler for a clustered vector processor
// Tracker, chain of shuffle slices and the cluster fork
`timescale 1ns/1ps

module shuffle_stage (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  // Request channel
  input  logic                                                        req_valid_i,
  output logic                                                        req_ready_o,
  input  shuffle_pkg::vew_e                                           req_vew_i,
  // Wide data input
  input  logic                                                        data_valid_i,
  output logic                                                        data_ready_o,
  input  shuffle_pkg::beat_t                                          data_i,
  input  logic                                                        data_last_i,
  // Cluster outputs
  output logic [shuffle_pkg::NR_CLUSTERS-1:0]                         cl_valid_o,
  input  logic [shuffle_pkg::NR_CLUSTERS-1:0]                         cl_ready_i,
  output logic [shuffle_pkg::NR_CLUSTERS-1:0][shuffle_pkg::CLUSTER_DW-1:0] cl_data_o,
  output logic                                                        cl_last_o
);

  import shuffle_pkg::*;

  // Link s feeds slice s, link NUM_STAGES feeds the fork
  logic [NUM_STAGES:0]   link_valid;
  logic [NUM_STAGES:0]   link_ready;
  logic [NUM_STAGES:0]   link_last;
  beat_t                 link_data [NUM_STAGES+1];

  logic [NUM_STAGES-1:0] stage_en_w;
  logic [NUM_STAGES-1:0] last_hs;
  logic                  pending;

  ////////////////////////////////////////////////////////////
  // Request tracking
  ////////////////////////////////////////////////////////////

  shuffle_tracker i_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_vew_i   (req_vew_i),
    .last_hs_i   (last_hs),
    .en_o        (stage_en_w),
    .pending_o   (pending)
  );

  // No beat may enter without a request that still expects it
  assign link_valid[0] = data_valid_i & pending;
  assign data_ready_o  = link_ready[0] & pending;
  assign link_data[0]  = data_i;
  assign link_last[0]  = data_last_i;

  ////////////////////////////////////////////////////////////
  // Shuffle pipeline
  ////////////////////////////////////////////////////////////

  // Slice 0 is combinational, the rest hold one register each
  for (genvar s = 0; s < NUM_STAGES; s++) begin : gen_slice
    shuffle_slice #(
      .STAGE   (s),
      .HAS_REG (s > 0)
    ) i_slice (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .valid_i   (link_valid[s]),
      .ready_o   (link_ready[s]),
      .data_i    (link_data[s]),
      .last_i    (link_last[s]),
      .en_i      (stage_en_w[s]),
      .valid_o   (link_valid[s+1]),
      .ready_i   (link_ready[s+1]),
      .data_o    (link_data[s+1]),
      .last_o    (link_last[s+1]),
      .last_hs_o (last_hs[s])
    );
  end

  // Broadcast to the clusters
  cluster_fork i_fork (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (link_valid[NUM_STAGES]),
    .ready_o    (link_ready[NUM_STAGES]),
    .data_i     (link_data[NUM_STAGES]),
    .last_i     (link_last[NUM_STAGES]),
    .cl_valid_o (cl_valid_o),
    .cl_ready_i (cl_ready_i),
    .cl_data_o  (cl_data_o),
    .cl_last_o  (cl_last_o)
  );

endmodule

// File: shuffle_stage_properties.sv
// Handshake properties of the read shuffler, bound to the top level
// Checks stable valid and payload until ready, and quiet outputs in reset
`timescale 1ns/1ps

module shuffle_stage_properties (
  input logic                                                        clk_i,
  input logic                                                        rst_ni,
  input logic                                                        req_ready_o,
  input logic                                                        data_valid_i,
  input logic                                                        data_ready_o,
  input shuffle_pkg::beat_t                                          data_i,
  input logic                                                        data_last_i,
  input logic [shuffle_pkg::NR_CLUSTERS-1:0]                         cl_valid_o,
  input logic [shuffle_pkg::NR_CLUSTERS-1:0]                         cl_ready_i,
  input logic [shuffle_pkg::NR_CLUSTERS-1:0][shuffle_pkg::CLUSTER_DW-1:0] cl_data_o,
  input logic                                                        cl_last_o
);

  import shuffle_pkg::*;

  // Outputs stay quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (cl_valid_o == '0 && !data_ready_o && req_ready_o))
    else $error("outputs active during reset");

  // Input beat held until taken
  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_valid_i && !data_ready_o |=> data_valid_i && $stable(data_i) && $stable(data_last_i))
    else $error("input beat changed before it was taken");

  ////////////////////////////////////////////////////////////
  // Per cluster
  ////////////////////////////////////////////////////////////

  for (genvar c = 0; c < NR_CLUSTERS; c++) begin : gen_cl
    // Offered beat stays until this cluster takes it
    a_cl_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cl_valid_o[c] && !cl_ready_i[c] |=>
        cl_valid_o[c] && $stable(cl_data_o[c]) && $stable(cl_last_o))
      else $error("cluster %0d beat dropped before ready", c);
  end

endmodule

bind shuffle_stage shuffle_stage_properties i_props (.*);

// File: tb_shuffle_stage.sv
// Testbench of the read shuffler with random requests, beats and cluster stalls
// Beats are checked per cluster against a model built from the stage rules
`timescale 1ns/1ps

module tb_shuffle_stage;

  import shuffle_pkg::*;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic                                   req_valid_i;
  logic                                   req_ready_o;
  vew_e                                   req_vew_i;
  logic                                   data_valid_i;
  logic                                   data_ready_o;
  beat_t                                  data_i;
  logic                                   data_last_i;
  logic [NR_CLUSTERS-1:0]                 cl_valid_o;
  logic [NR_CLUSTERS-1:0]                 cl_ready_i;
  logic [NR_CLUSTERS-1:0][CLUSTER_DW-1:0] cl_data_o;
  logic                                   cl_last_o;

  integer seed = 32'h3419_fafb;
  int     errors;
  int     test_err;
  int     tests_run;
  int     tests_failed;
  string  test_name;
  bit     bp_mode;

  // Model state with the widths of requests still taking beats and the expected beats
  vew_e   req_vews [$];
  beat_t  exp_beats [$];
  bit     exp_last [$];
  int     rx_cnt [NR_CLUSTERS];

  // Cluster ready for the coming cycle
  logic [NR_CLUSTERS-1:0] ready_next;

  shuffle_stage i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////
  // Model
  //////////////////////////////////////////////////////////////

  // Output block o of a group of 2*NR_CLUSTERS blocks comes from block (o%2)*NR_CLUSTERS+o/2
  function automatic beat_t perm_model(beat_t b, int stage);
    int    blk;
    int    grp;
    int    pos;
    int    src;
    beat_t r;
    blk = NR_LANES << stage;
    r   = '0;
    for (int o = 0; o < TOTAL_DW / blk; o++) begin
      grp = o / (2 * NR_CLUSTERS);
      pos = o % (2 * NR_CLUSTERS);
      src = grp * 2 * NR_CLUSTERS + (pos % 2) * NR_CLUSTERS + pos / 2;
      for (int k = 0; k < blk; k++) begin
        r[o * blk + k] = b[src * blk + k];
      end
    end
    return r;
  endfunction

  function automatic beat_t shuffle_model(beat_t b, vew_e vew);
    beat_t r;
    r = b;
    for (int s = 0; s < NUM_STAGES; s++) begin
      if (stage_en(s, vew)) begin
        r = perm_model(r, s);
      end
    end
    return r;
  endfunction

  task automatic check_val(string what, beat_t exp, beat_t act);
    assert (exp == act) else begin
      $display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Cluster side with random ready and per-cluster checks
  //////////////////////////////////////////////////////////////

  initial begin
    cl_ready_i = '0;
    for (int c = 0; c < NR_CLUSTERS; c++) begin
      rx_cnt[c] = 0;
    end
    forever begin
      // Next ready per cluster is drawn after each rising edge
      @(posedge clk_i);
      for (int c = 0; c < NR_CLUSTERS; c++) begin
        ready_next[c] = bp_mode ? (($random(seed) % 4) != 0) : 1'b1;
      end
      @(negedge clk_i);
      cl_ready_i = ready_next;
      #1;
      // Handshakes that complete on the coming rising edge
      for (int c = 0; c < NR_CLUSTERS; c++) begin
        if (rst_ni && cl_valid_o[c] && cl_ready_i[c]) begin
          assert (rx_cnt[c] < exp_beats.size()) else begin
            $display("Cluster %0d received a beat that was never sent in %s", c, test_name);
            errors++;
          end
          if (rx_cnt[c] < exp_beats.size()) begin
            check_val($sformatf("cluster %0d data", c),
                      beat_t'(exp_beats[rx_cnt[c]][c * CLUSTER_DW +: CLUSTER_DW]),
                      beat_t'(cl_data_o[c]));
            check_val($sformatf("cluster %0d last", c),
                      beat_t'(exp_last[rx_cnt[c]]), beat_t'(cl_last_o));
          end
          rx_cnt[c]++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////

  task automatic send_request(vew_e vew);
    bit rdy;
    int t;
    t = 0;
    while (1) begin
      @(negedge clk_i);
      req_valid_i = 1'b1;
      req_vew_i   = vew;
      #1;
      rdy = req_ready_o;
      @(posedge clk_i);
      if (rdy) begin
        req_vews.push_back(vew);
        break;
      end
      t++;
      if (t > 200) begin
        $display("Timeout waiting for the request channel in %s", test_name);
        errors++;
        break;
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic send_beat(bit last, int gap_max);
    beat_t b;
    bit    rdy;
    int    t;
    for (int w = 0; w < TOTAL_DW / 32; w++) begin
      b[w * 32 +: 32] = $random(seed);
    end
    if (gap_max > 0) begin
      repeat ($unsigned($random(seed)) % (gap_max + 1)) begin
        @(negedge clk_i);
        data_valid_i = 1'b0;
      end
    end
    t = 0;
    while (1) begin
      @(negedge clk_i);
      data_valid_i = 1'b1;
      data_i       = b;
      data_last_i  = last;
      #1;
      rdy = data_ready_o;
      @(posedge clk_i);
      if (rdy) begin
        exp_beats.push_back(shuffle_model(b, req_vews[0]));
        exp_last.push_back(last);
        if (last) begin
          void'(req_vews.pop_front());
        end
        break;
      end
      t++;
      if (t > 500) begin
        $display("Timeout waiting for the data input in %s", test_name);
        errors++;
        break;
      end
    end
    @(negedge clk_i);
    data_valid_i = 1'b0;
  endtask

  task automatic send_beats(int n, int gap_max);
    for (int i = 0; i < n; i++) begin
      send_beat(i == n - 1, gap_max);
    end
  endtask

  // Every cluster has taken every beat sent so far
  task automatic wait_drain();
    int  t;
    bit  all;
    t = 0;
    while (1) begin
      @(negedge clk_i);
      #2;
      all = 1'b1;
      for (int c = 0; c < NR_CLUSTERS; c++) begin
        all &= (rx_cnt[c] == exp_beats.size());
      end
      if (all) break;
      t++;
      if (t > 2000) begin
        $display("Timeout waiting for the clusters to drain in %s", test_name);
        errors++;
        break;
      end
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_err  = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_err) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_err);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////

  initial begin
    int lat;
    int t;
    int v;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_vew_i    = EW8;
    data_valid_i = 1'b0;
    data_i       = '0;
    data_last_i  = 1'b0;
    bp_mode      = 1'b0;
    errors       = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("reset");
    #1;
    check_val("req_ready_o", beat_t'(1), beat_t'(req_ready_o));
    check_val("data_ready_o", beat_t'(0), beat_t'(data_ready_o));
    check_val("cl_valid_o", beat_t'(0), beat_t'(cl_valid_o));
    end_test();

    for (int w = 0; w < 3; w++) begin
      start_test($sformatf("width_%0d", 8 << w));
      send_request(vew_e'(w[1:0]));
      send_beats(3, 0);
      wait_drain();
      end_test();
    end

    start_test("mixed_widths");
    send_request(EW8);
    send_request(EW32);
    send_request(EW16);
    send_beats(2, 0);
    send_beats(3, 0);
    send_beats(2, 0);
    wait_drain();
    end_test();

    start_test("random_backpressure");
    bp_mode = 1'b1;
    for (int r = 0; r < 20; r++) begin
      v = $unsigned($random(seed)) % 3;
      send_request(vew_e'(v[1:0]));
      send_beats(1 + $unsigned($random(seed)) % 4, 2);
    end
    wait_drain();
    bp_mode = 1'b0;
    end_test();

    start_test("queue_full");
    for (int r = 0; r < NUM_TRACKERS; r++) begin
      send_request(EW16);
    end
    #1;
    check_val("req_ready_o when full", beat_t'(0), beat_t'(req_ready_o));
    send_beats(1, 0);
    t = 0;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #1;
      t++;
      if (t > 100) begin
        $display("req_ready_o never returned high in %s", test_name);
        errors++;
        break;
      end
    end
    for (int r = 1; r < NUM_TRACKERS; r++) begin
      send_beats(1, 0);
    end
    wait_drain();
    end_test();

    start_test("latency");
    send_request(EW8);
    // Count rising edges from the accepting one to the first cluster valid
    send_beat(1'b1, 0);
    lat = 1;
    t = 0;
    while (1) begin
      #1;
      if (cl_valid_o != '0) break;
      @(posedge clk_i);
      lat++;
      @(negedge clk_i);
      t++;
      if (t > 50) begin
        $display("No cluster valid after the beat in %s", test_name);
        errors++;
        break;
      end
    end
    check_val("latency", beat_t'(4), beat_t'(lat));
    wait_drain();
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: shuffle_stage.f
shuffle_pkg.sv
shuffle_perm.sv
shuffle_slice.sv
shuffle_tracker.sv
cluster_fork.sv
shuffle_stage.sv
shuffle_stage_properties.sv
tb_shuffle_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the shuffler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f shuffle_stage.f \
  --top-module tb_shuffle_stage \
  -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
